/* src.f */
source/segmentPkg.sv
source/scanPkg.sv
source/scanTimer.sv
source/digitScanner.sv
source/digitEncode.sv
source/hexDisplay.sv
sim/hexDisplaySva_sva.sv
sim/hexDisplayTb.sv

/* Bender.yml */
package:
  name: hexDisplay

sources:
  # Synthesizable display driver
  - files:
      - source/segmentPkg.sv
      - source/scanPkg.sv
      - source/scanTimer.sv
      - source/digitScanner.sv
      - source/digitEncode.sv
      - source/hexDisplay.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/hexDisplaySva_sva.sv
      - sim/hexDisplayTb.sv

/* sim/hexDisplayTb.sv */
// Needs a simulator with concurrent assertions; the bound hexDisplaySva does all output checks
module hexDisplayTb
        import segmentPkg::*, scanPkg::*;
();
        timeunit 1ns;
        timeprecision 100ps;

        // Clock period and drive offset after the rising edge
        localparam int CLOCK_PERIOD = 40;
        localparam int DRIVE_DELAY = 2;

        // One round lights every digit once
        localparam int ROUND_CYCLES = DIGIT_COUNT * SCAN_PERIOD;

        // Five tests of two rounds each
        localparam int TEST_CYCLES = 5 * 2 * ROUND_CYCLES;

        // Values with leading zeros at different depths
        localparam logic [DIGIT_COUNT*4-1:0] BLANK_VALUES [8] = '{
                24'h000000, 24'h00000A, 24'h00F000, 24'h0B0000,
                24'h000100, 24'h100000, 24'h000020, 24'h0000C0
        };

        logic                     CLOCK = 1'b0;
        logic                     RST_n;
        logic [DIGIT_COUNT*4-1:0] displayValue;
        logic [DIGIT_COUNT-1:0]   pointMask;
        logic                     blankLeading;
        logic [7:0]               segments;
        logic [DIGIT_COUNT-1:0]   digitEnable;

        integer seed = 70925;
        // Assertion failures seen when the current test began
        int     startFails;
        int     passedTests = 0;
        int     failedTests = 0;

        hexDisplay dut_i
        (
                .CLOCK        (CLOCK),
                .RST_n        (RST_n),
                .displayValue (displayValue),
                .pointMask    (pointMask),
                .blankLeading (blankLeading),
                .segments     (segments),
                .digitEnable  (digitEnable)
        );

        always #(CLOCK_PERIOD / 2) CLOCK = ~CLOCK;

        // New inputs just after the rising edge
        task automatic driveCycle(input logic [DIGIT_COUNT*4-1:0] value,
                input logic [DIGIT_COUNT-1:0] mask, input logic blank);
                @(posedge CLOCK);
                #(DRIVE_DELAY);
                displayValue = value;
                pointMask    = mask;
                blankLeading = blank;
        endtask

        task automatic startTest();
                startFails = dut_i.sva_i.failCount;
        endtask

        task automatic finishTest(input int number, input string name);
                int fails;
                fails = dut_i.sva_i.failCount - startFails;
                $display("Test %0d %s: %0d failures", number, name, fails);
                if (fails == 0)
                begin
                        passedTests++;
                end
                else
                begin
                        failedTests++;
                end
        endtask

        task automatic resetTest();
                startTest();
                // Real falling edge on reset
                #1;
                RST_n = 1'b0;
                repeat (5) @(posedge CLOCK);
                #(DRIVE_DELAY);
                RST_n = 1'b1;
                // Reach past the first cycle out of reset
                driveCycle('0, '0, 1'b0);
                driveCycle('0, '0, 1'b0);
                finishTest(1, "reset");
        endtask

        task automatic scanOrderTest();
                startTest();
                for (int c = 0; c < 2 * ROUND_CYCLES; c++)
                begin
                        driveCycle(24'h81C4E7, '0, 1'b0);
                end
                finishTest(2, "scan order");
        endtask

        task automatic hexTest();
                logic [3:0]  nibble;
                logic [31:0] randWord;
                startTest();
                // All digits share one nibble that steps each cycle
                for (int c = 0; c < ROUND_CYCLES; c++)
                begin
                        nibble = c[3:0];
                        driveCycle({DIGIT_COUNT{nibble}}, '0, 1'b0);
                end
                for (int c = 0; c < ROUND_CYCLES; c++)
                begin
                        randWord = $random(seed);
                        driveCycle(randWord[DIGIT_COUNT*4-1:0], '0, 1'b0);
                end
                finishTest(3, "hex encoding");
        endtask

        task automatic blankTest();
                startTest();
                for (int c = 0; c < 2 * ROUND_CYCLES; c++)
                begin
                        driveCycle(BLANK_VALUES[c % 8], '0, 1'b1);
                end
                finishTest(4, "leading blank");
        endtask

        task automatic pointTest();
                logic [31:0] valueWord;
                logic [31:0] maskWord;
                logic [31:0] shiftWord;
                startTest();
                for (int c = 0; c < 2 * ROUND_CYCLES; c++)
                begin
                        valueWord = $random(seed);
                        maskWord  = $random(seed);
                        shiftWord = $random(seed);
                        // Shifted value gets leading zeros, sparse mask, blanking most cycles
                        driveCycle(valueWord[DIGIT_COUNT*4-1:0] >> (4 * (shiftWord % DIGIT_COUNT)),
                                maskWord[5:0] & maskWord[13:8], shiftWord[31] | shiftWord[30]);
                end
                finishTest(5, "decimal point");
        endtask

        initial
        begin
                RST_n        = 1'b1;
                displayValue = '0;
                pointMask    = '0;
                blankLeading = 1'b0;
                resetTest();
                scanOrderTest();
                hexTest();
                blankTest();
                pointTest();
                $display("Tests passed: %0d, failed: %0d", passedTests, failedTests);
                if (failedTests == 0)
                begin
                        $display("*** TEST PASSED ***");
                end
                else
                begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

        // Twice the planned test length
        initial
        begin
                #(2 * TEST_CYCLES * CLOCK_PERIOD);
                $display("Timeout: tests did not finish");
                $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

/* sim/hexDisplaySva_sva.sv */
// Inputs must change away from the rising edge; order and dwell checks expect a single reset at start
module hexDisplaySva
        import segmentPkg::*, scanPkg::*;
(
        input logic                     CLOCK,
        input logic                     RST_n,
        input logic [DIGIT_COUNT*4-1:0] displayValue,
        input logic [DIGIT_COUNT-1:0]   pointMask,
        input logic                     blankLeading,
        input logic [7:0]               segments,
        input logic [DIGIT_COUNT-1:0]   digitEnable
);
        timeunit 1ns;
        timeprecision 100ps;

        // Failed assertions so far
        int failCount = 0;

        // Inputs one clock back, matching the output latency
        logic [DIGIT_COUNT*4-1:0] lastValue;
        logic [DIGIT_COUNT-1:0]   lastMask;
        logic                     lastBlank;

        // Previous enable pattern and length of the current run
        logic [DIGIT_COUNT-1:0] lastEnable;
        int                     dwellCount;

        // Expected byte for the digit lit now
        logic [7:0] expected;

        // Position of the low bit in an active-low enable
        function automatic int activeDigit(input logic [DIGIT_COUNT-1:0] enable);
                int found;
                found = 0;
                for (int d = 0; d < DIGIT_COUNT; d++)
                begin
                        if (!enable[d])
                        begin
                                found = d;
                        end
                end
                return found;
        endfunction

        // Next lit digit, wrapping from the top digit to digit 0
        function automatic logic [DIGIT_COUNT-1:0] nextDigit(input logic [DIGIT_COUNT-1:0] lit);
                return {lit[DIGIT_COUNT-2:0], lit[DIGIT_COUNT-1]};
        endfunction

        // Segment byte the display should show for one digit
        function automatic logic [7:0] expectedSegments(input logic [DIGIT_COUNT*4-1:0] value,
                input logic [DIGIT_COUNT-1:0] mask, input logic blank, input int digit);
                logic       dark;
                logic [7:0] code;
                // Digit 0 always shows
                dark = blank && (digit != 0);
                for (int j = digit; j < DIGIT_COUNT; j++)
                begin
                        // Any nonzero digit at or above keeps this one lit
                        if (value[j*4 +: 4] != 4'h0)
                        begin
                                dark = 1'b0;
                        end
                        // So does a point on a higher digit
                        if (j > digit && mask[j])
                        begin
                                dark = 1'b0;
                        end
                end
                code = SEGMENT_CODES[value[digit*4 +: 4]];
                if (mask[digit])
                begin
                        code[7] = 1'b0;
                end
                if (dark)
                begin
                        code = SEGMENT_OFF;
                end
                return code;
        endfunction

        assign expected = expectedSegments(lastValue, lastMask, lastBlank,
                activeDigit(digitEnable));

        // Delayed inputs and dwell counter
        always_ff @(posedge CLOCK or negedge RST_n)
        begin
                if (!RST_n)
                begin
                        lastValue  <= '0;
                        lastMask   <= '0;
                        lastBlank  <= 1'b0;
                        lastEnable <= '1;
                        dwellCount <= 0;
                end
                else
                begin
                        lastValue  <= displayValue;
                        lastMask   <= pointMask;
                        lastBlank  <= blankLeading;
                        lastEnable <= digitEnable;
                        // A new enable pattern starts a fresh run
                        if (digitEnable != lastEnable)
                        begin
                                dwellCount <= 1;
                        end
                        else
                        begin
                                dwellCount <= dwellCount + 1;
                        end
                end
        end

        // Dark in reset and in the first cycle after release
        resetDark: assert property (@(posedge CLOCK)
                (!RST_n || $rose(RST_n)) |-> (segments == SEGMENT_OFF && digitEnable == '1))
        else
        begin
                failCount++;
                $error("Error at %0t: display lit around reset", $time);
        end

        // Exactly one anode driven
        oneDigitLit: assert property (@(posedge CLOCK) disable iff (!RST_n)
                $past(RST_n) |-> $onehot(~digitEnable))
        else
        begin
                failCount++;
                $error("Error at %0t: enable %b is not one-hot", $time, $sampled(digitEnable));
        end

        // Lit digit only ever steps up by one
        stepOrder: assert property (@(posedge CLOCK) disable iff (!RST_n)
                ($past(RST_n, 2) && digitEnable != $past(digitEnable))
                |-> (~digitEnable == nextDigit(~$past(digitEnable))))
        else
        begin
                failCount++;
                $error("Error at %0t: digit skipped, enable %b", $time, $sampled(digitEnable));
        end

        // First step one period plus the latency cycle after release
        firstMove: assert property (@(posedge CLOCK) disable iff (!RST_n)
                $rose(RST_n) |-> ##(SCAN_PERIOD + 1) (digitEnable != $past(digitEnable)))
        else
        begin
                failCount++;
                $error("Error at %0t: first digit step came at the wrong time", $time);
        end

        // Each digit held for exactly one scan period
        dwellExact: assert property (@(posedge CLOCK) disable iff (!RST_n)
                ($past(RST_n, 2) && digitEnable != lastEnable) |-> (dwellCount == SCAN_PERIOD))
        else
        begin
                failCount++;
                $error("Error at %0t: digit held %0d cycles", $time, $sampled(dwellCount));
        end

        dwellBound: assert property (@(posedge CLOCK) disable iff (!RST_n)
                dwellCount <= SCAN_PERIOD)
        else
        begin
                failCount++;
                $error("Error at %0t: scan stopped on one digit", $time);
        end

        // Bars follow the hex table and the blanking rule
        segmentBars: assert property (@(posedge CLOCK) disable iff (!RST_n)
                $past(RST_n) |-> (segments[6:0] == expected[6:0]))
        else
        begin
                failCount++;
                $error("Error at %0t: segments %h, expected %h", $time,
                        $sampled(segments), $sampled(expected));
        end

        // Point lit only for a masked digit that is shown
        segmentPoint: assert property (@(posedge CLOCK) disable iff (!RST_n)
                $past(RST_n) |-> (segments[7] == expected[7]))
        else
        begin
                failCount++;
                $error("Error at %0t: point is %b, expected %b", $time,
                        $sampled(segments[7]), $sampled(expected[7]));
        end

endmodule

bind hexDisplay hexDisplaySva sva_i
(
        .CLOCK        (CLOCK),
        .RST_n        (RST_n),
        .displayValue (displayValue),
        .pointMask    (pointMask),
        .blankLeading (blankLeading),
        .segments     (segments),
        .digitEnable  (digitEnable)
);

/* source/hexDisplay.sv */
// Six hex digits multiplexed at SCAN_PERIOD cycles each; no dimming, no dead time between digits
module hexDisplay
        import segmentPkg::*;
(
        input  logic                     CLOCK,
        input  logic                     RST_n,
        input  logic [DIGIT_COUNT*4-1:0] displayValue,
        input  logic [DIGIT_COUNT-1:0]   pointMask,
        input  logic                     blankLeading,
        output logic [7:0]               segments,
        output logic [DIGIT_COUNT-1:0]   digitEnable
);

        // Dwell strobe from the prescaler
        logic scanTick;

        // Current digit and its decoded fields
        logic [DIGIT_BITS-1:0] digitIndex;
        logic [3:0]            digitNibble;
        logic                  digitBlank;
        logic                  digitPoint;

        // Prescaler, one strobe per digit dwell
        scanTimer timer_i
        (
                .CLOCK    (CLOCK),
                .RST_n    (RST_n),
                .scanTick (scanTick)
        );

        // Digit rotation and per-digit selection
        digitScanner scanner_i
        (
                .CLOCK        (CLOCK),
                .RST_n        (RST_n),
                .scanTick     (scanTick),
                .displayValue (displayValue),
                .pointMask    (pointMask),
                .blankLeading (blankLeading),
                .digitIndex   (digitIndex),
                .digitNibble  (digitNibble),
                .digitBlank   (digitBlank),
                .digitPoint   (digitPoint)
        );

        // Registered segment pattern and anode enable
        digitEncode encoder_i
        (
                .CLOCK       (CLOCK),
                .RST_n       (RST_n),
                .digitIndex  (digitIndex),
                .digitNibble (digitNibble),
                .digitBlank  (digitBlank),
                .digitPoint  (digitPoint),
                .segments    (segments),
                .digitEnable (digitEnable)
        );

endmodule

/* source/digitEncode.sv */
// Outputs are active low for a common-anode part; one cycle of latency from the scanner inputs
module digitEncode
        import segmentPkg::*;
(
        input  logic                   CLOCK,
        input  logic                   RST_n,
        input  logic [DIGIT_BITS-1:0]  digitIndex,
        input  logic [3:0]             digitNibble,
        input  logic                   digitBlank,
        input  logic                   digitPoint,
        output logic [7:0]             segments,
        output logic [DIGIT_COUNT-1:0] digitEnable
);

        // Segment byte for the current digit, before the register
        segmentWord patternWord;

        // Active-low one-hot enable, before the register
        logic [DIGIT_COUNT-1:0] enableNext;

        // Hex lookup with point and blanking applied
        always_comb
        begin
                // Table entry, point dark by default
                patternWord.raw = SEGMENT_CODES[digitNibble];

                // Lit point pulls the point field low
                if (digitPoint)
                begin
                        patternWord.field.point = 1'b0;
                end

                // Blank digit goes fully dark, the point as well
                if (digitBlank)
                begin
                        patternWord.raw = SEGMENT_OFF;
                end
        end

        // Index to one-hot enable
        // Only the selected anode is pulled low
        always_comb
        begin
                for (int i = 0; i < DIGIT_COUNT; i++)
                begin
                        enableNext[i] = (digitIndex != DIGIT_BITS'(i));
                end
        end

        // Segments and anode enable share one register stage
        // so a digit never shows the pattern of its neighbour
        always_ff @(posedge CLOCK or negedge RST_n)
        begin
                if (!RST_n)
                begin
                        // Whole display dark in reset
                        segments    <= SEGMENT_OFF;
                        digitEnable <= '1;
                end
                else
                begin
                        segments    <= patternWord.raw;
                        digitEnable <= enableNext;
                end
        end

endmodule

/* source/digitScanner.sv */
// Digit 0 is the low nibble and is never blanked; blanking and point follow inputs combinationally
module digitScanner
        import segmentPkg::*;
(
        input  logic                     CLOCK,
        input  logic                     RST_n,
        input  logic                     scanTick,
        input  logic [DIGIT_COUNT*4-1:0] displayValue,
        input  logic [DIGIT_COUNT-1:0]   pointMask,
        input  logic                     blankLeading,
        output logic [DIGIT_BITS-1:0]    digitIndex,
        output logic [3:0]               digitNibble,
        output logic                     digitBlank,
        output logic                     digitPoint
);

        // Last valid index before the wrap
        localparam logic [DIGIT_BITS-1:0] LAST_DIGIT = DIGIT_BITS'(DIGIT_COUNT - 1);

        // Value split into one nibble per digit
        logic [3:0] nibbleAt [DIGIT_COUNT];

        // Per-digit blank decision, bit i for digit i
        logic [DIGIT_COUNT-1:0] blankVector;

        // Rotating digit index
        // Steps once per strobe, wraps from the top digit to digit 0
        always_ff @(posedge CLOCK or negedge RST_n)
        begin
                if (!RST_n)
                begin
                        digitIndex <= '0;
                end
                else if (scanTick)
                begin
                        if (digitIndex == LAST_DIGIT)
                        begin
                                digitIndex <= '0;
                        end
                        else
                        begin
                                digitIndex <= digitIndex + 1'b1;
                        end
                end
        end

        // Unpack the display value
        always_comb
        begin
                for (int i = 0; i < DIGIT_COUNT; i++)
                begin
                        nibbleAt[i] = displayValue[i*4 +: 4];
                end
        end

        // Leading-zero blanking, walked from the most significant digit down
        // A run of zero digits is blanked while nothing above it is shown
        always_comb
        begin
                logic leadRun;

                // Run only starts when blanking is requested
                leadRun = blankLeading;
                blankVector = '0;
                for (int i = DIGIT_COUNT - 1; i > 0; i--)
                begin
                        // A nonzero digit ends the run for itself and all below
                        leadRun = leadRun && (nibbleAt[i] == 4'h0);
                        blankVector[i] = leadRun;
                        // A lit point here keeps every lower digit visible
                        leadRun = leadRun && !pointMask[i];
                end
                // Digit 0 always shows, so a zero value reads as a single 0
                blankVector[0] = 1'b0;
        end

        // Selection for the digit now being driven
        assign digitNibble = nibbleAt[digitIndex];
        assign digitBlank  = blankVector[digitIndex];
        assign digitPoint  = pointMask[digitIndex];

endmodule

/* source/scanTimer.sv */
// Strobe period is fixed by SCAN_PERIOD in scanPkg; there is no run-time rate control
module scanTimer
        import scanPkg::*;
(
        input  logic CLOCK,
        input  logic RST_n,
        output logic scanTick
);

        // Reload value, one less than the period since zero is counted
        localparam logic [SCAN_BITS-1:0] RELOAD = SCAN_BITS'(SCAN_PERIOD - 1);

        // Cycles left in the current dwell
        logic [SCAN_BITS-1:0] scanCount;

        // Down counter, reloads after reaching zero
        always_ff @(posedge CLOCK or negedge RST_n)
        begin
                if (!RST_n)
                begin
                        // Start a full period so the first strobe is one period out
                        scanCount <= RELOAD;
                end
                else if (scanCount == '0)
                begin
                        scanCount <= RELOAD;
                end
                else
                begin
                        scanCount <= scanCount - 1'b1;
                end
        end

        // One cycle strobe on the reload cycle
        // Counter sits at RELOAD in reset, so the strobe stays low there
        assign scanTick = (scanCount == '0);

endmodule

/* source/scanPkg.sv */
// Scan period is kept short for simulation; a board build raises SCAN_PERIOD to a few kHz scan
package scanPkg;

        // Clock cycles each digit stays lit
        // Must be at least 2 so the counter can reload
        localparam int SCAN_PERIOD = 16;

        // Width of the down counter that spans one period
        // Holds values from SCAN_PERIOD-1 down to 0
        localparam int SCAN_BITS = (SCAN_PERIOD > 2) ? $clog2(SCAN_PERIOD) : 1;

endpackage

/* source/segmentPkg.sv */
// Segment codes assume a common-anode part with active-low segments and bit 7 as the point
package segmentPkg;

        // Number of multiplexed digits on the display
        localparam int DIGIT_COUNT = 6;

        // Width of a digit index, enough for 0 to DIGIT_COUNT-1
        localparam int DIGIT_BITS = 3;

        // Active-low patterns for hex 0 to F
        // Bit order is dp g f e d c b a, a zero lights the segment
        // Point bit is high in every entry, the encoder clears it when needed
        localparam logic [7:0] SEGMENT_CODES [16] = '{
                8'b1100_0000,
                8'b1111_1001,
                8'b1010_0100,
                8'b1011_0000,
                8'b1001_1001,
                8'b1001_0010,
                8'b1000_0010,
                8'b1111_1000,
                8'b1000_0000,
                8'b1001_0000,
                // Letters A to F, lower case b and d
                8'b1000_1000,
                8'b1000_0011,
                8'b1100_0110,
                8'b1010_0001,
                8'b1000_0110,
                8'b1000_1110
        };

        // Every segment and the point dark
        localparam logic [7:0] SEGMENT_OFF = 8'b1111_1111;

        // One segment byte, seen either as the raw pin word
        // or split into the point and the seven bars
        typedef union packed
        {
                // Byte as it leaves on the segment pins
                logic [7:0] raw;
                // Same byte with named fields
                struct packed
                {
                        // Decimal point, low when lit
                        logic point;
                        // Bars g down to a, low when lit
                        logic [6:0] bars;
                } field;
        } segmentWord;

endpackage
